/* compile.f */
rtl/can_pkg.sv
rtl/can_bit_destuffer.sv
rtl/can_crc15.sv
rtl/can_field_shifter.sv
rtl/can_frame_fsm.sv
rtl/can_decoder.sv
verif/can_decoder_props.sv
verif/tb_can_decoder.sv

/* verif/tb_can_decoder.sv */
`default_nettype none

module tb_can_decoder;

	// ==========================================================
	// DUT signals
	// ==========================================================

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	logic error_out;
	logic frame_done;
	can_pkg::id_a_t id_a;
	can_pkg::id_b_t id_b;
	can_pkg::dlc_t dlc;
	can_pkg::data_t data;
	can_pkg::crc_t crc;
	logic ide;
	logic rtr;
	logic srr;
	logic reserved1;
	logic reserved0;
	logic ack_slot;

	// Encoded frame, SOF through the last EOF bit, stuff bits included
	logic frame_bits[$];
	// Position of the first data bit, and of each stuff bit
	int data_pos;
	int stuff_pos[$];
	// CRC as sent on the bus
	can_pkg::crc_t frame_crc;
	// Levels sent in r1 and r0
	logic [1:0] reserved_tx;

	// Output events seen in the cycle after a strobe
	bit done_seen;
	bit error_seen;
	// Bus bit number of each event within the current frame
	int bits_driven;
	int done_bit;
	int error_bit;
	// Recessive bits since the last dominant one
	int recessive_run;

	logic [31:0] rng;
	int value_errors;
	int other_errors;

	can_decoder dut (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.error_out    (error_out),
		.frame_done   (frame_done),
		.id_a         (id_a),
		.id_b         (id_b),
		.dlc          (dlc),
		.data         (data),
		.crc          (crc),
		.ide          (ide),
		.rtr          (rtr),
		.srr          (srr),
		.reserved1    (reserved1),
		.reserved0    (reserved0),
		.ack_slot     (ack_slot)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ==========================================================
	// Reference helpers
	// ==========================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift(rng);
		return rng;
	endfunction

	// One bit of the CAN generator, MSB out first
	function automatic can_pkg::crc_t crc_update(input can_pkg::crc_t c, input logic b);
		logic fb;
		fb = b ^ c[can_pkg::CRC_LEN-1];
		return (c << 1) ^ (fb ? can_pkg::CRC_POLY : '0);
	endfunction

	// Remote frames carry nothing, DLC above 8 still means 8 bytes
	function automatic int data_bit_count(input logic remote, input can_pkg::dlc_t code);
		if (remote)
			return 0;
		if (code > can_pkg::MAX_DATA_BYTES)
			return can_pkg::MAX_DATA_BYTES * 8;
		return code * 8;
	endfunction

	// ==========================================================
	// Frame encoder
	// ==========================================================

	task automatic encode_frame(
		input logic ext,
		input can_pkg::id_a_t ida,
		input can_pkg::id_b_t idb,
		input logic remote,
		input can_pkg::dlc_t code,
		input can_pkg::data_t payload,
		input can_pkg::crc_t crc_flip
	);
		logic raw[$];
		int i;
		int data_first;
		int nbits;
		int run;
		logic last;
		can_pkg::crc_t c;

		// SOF and base identifier
		raw.push_back(1'b0);
		for (i = can_pkg::ID_A_LEN - 1; i >= 0; i--)
			raw.push_back(ida[i]);
		if (ext)
		begin
			// SRR then IDE, both recessive
			raw.push_back(1'b1);
			raw.push_back(1'b1);
			for (i = can_pkg::ID_B_LEN - 1; i >= 0; i--)
				raw.push_back(idb[i]);
			raw.push_back(remote);
			// r1
			raw.push_back(reserved_tx[1]);
		end
		else
		begin
			raw.push_back(remote);
			// Dominant IDE
			raw.push_back(1'b0);
		end
		// r0
		raw.push_back(reserved_tx[0]);
		for (i = can_pkg::DLC_LEN - 1; i >= 0; i--)
			raw.push_back(code[i]);
		nbits = data_bit_count(remote, code);
		data_first = raw.size();
		for (i = nbits - 1; i >= 0; i--)
			raw.push_back(payload[i]);

		// CRC over SOF to end of data, zero seed
		c = '0;
		for (i = 0; i < raw.size(); i++)
			c = crc_update(c, raw[i]);
		frame_crc = c ^ crc_flip;
		for (i = can_pkg::CRC_LEN - 1; i >= 0; i--)
			raw.push_back(frame_crc[i]);

		// Stuff from SOF to the last CRC bit
		frame_bits.delete();
		stuff_pos.delete();
		run = 0;
		last = 1'b1;
		for (i = 0; i < raw.size(); i++)
		begin
			if (i == data_first)
				data_pos = frame_bits.size();
			frame_bits.push_back(raw[i]);
			if (raw[i] == last)
				run++;
			else
			begin
				run = 1;
				last = raw[i];
			end
			if (run == can_pkg::STUFF_RUN)
			begin
				stuff_pos.push_back(frame_bits.size());
				frame_bits.push_back(~last);
				last = ~last;
				run = 1;
			end
		end

		// CRC delimiter, dominant ack, ack delimiter, EOF
		frame_bits.push_back(1'b1);
		frame_bits.push_back(1'b0);
		frame_bits.push_back(1'b1);
		for (i = 0; i < can_pkg::EOF_LEN; i++)
			frame_bits.push_back(1'b1);
	endtask

	// ==========================================================
	// Bus driving
	// ==========================================================

	// One strobe every four clocks, outputs sampled at the next falling edge
	task automatic drive_bit(input logic b);
		repeat (3) @(posedge clock);
		sample_point <= 1'b1;
		rx_bit <= b;
		@(posedge clock);
		sample_point <= 1'b0;
		bits_driven++;
		if (b)
			recessive_run++;
		else
			recessive_run = 0;
		@(negedge clock);
		if (frame_done)
		begin
			done_seen = 1'b1;
			done_bit = bits_driven;
		end
		if (error_out && !error_seen)
		begin
			error_seen = 1'b1;
			error_bit = bits_driven;
		end
	endtask

	task automatic send_frame();
		int i;
		for (i = 0; i < frame_bits.size(); i++)
			drive_bit(frame_bits[i]);
	endtask

	task automatic send_idle(input int n);
		repeat (n) drive_bit(1'b1);
	endtask

	// Intermission bits keep the bus recessive while waiting
	task automatic wait_frame_done();
		int n;
		n = 0;
		while (!done_seen && (n < 4))
		begin
			drive_bit(1'b1);
			n++;
		end
		if (!done_seen)
		begin
			$display("Timeout at %0t: frame_done never pulsed after the frame", $time);
			other_errors++;
		end
	endtask

	task automatic wait_error_release();
		int n;
		n = 0;
		while (error_out && (n < 3 * can_pkg::IDLE_RUN))
		begin
			drive_bit(1'b1);
			n++;
		end
		if (error_out)
		begin
			$display("Timeout at %0t: error_out stayed high on an idle bus", $time);
			other_errors++;
		end
		else if (recessive_run != can_pkg::IDLE_RUN)
		begin
			$display("Fail %0t error_out release run got %0d expected %0d",
				$time, recessive_run, can_pkg::IDLE_RUN);
			value_errors++;
		end
	endtask

	// ==========================================================
	// Compare tasks
	// ==========================================================

	task automatic id_a_cmp(input string name, input can_pkg::id_a_t got,
		input can_pkg::id_a_t exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic id_b_cmp(input string name, input can_pkg::id_b_t got,
		input can_pkg::id_b_t exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic dlc_cmp(input string name, input can_pkg::dlc_t got,
		input can_pkg::dlc_t exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic data_cmp(input string name, input can_pkg::data_t got,
		input can_pkg::data_t exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic crc_cmp(input string name, input can_pkg::crc_t got,
		input can_pkg::crc_t exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic bit_cmp(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %0t %s got %b expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// ==========================================================
	// Frame runners
	// ==========================================================

	task automatic run_clean_frame(
		input logic ext,
		input can_pkg::id_a_t ida,
		input can_pkg::id_b_t idb,
		input logic remote,
		input can_pkg::dlc_t code,
		input can_pkg::data_t payload
	);
		can_pkg::data_t exp_data;
		int nbits;
		int i;

		encode_frame(ext, ida, idb, remote, code, payload, '0);
		// Right-aligned, upper bytes zero
		nbits = data_bit_count(remote, code);
		exp_data = '0;
		for (i = 0; i < nbits; i++)
			exp_data[i] = payload[i];

		done_seen = 1'b0;
		error_seen = 1'b0;
		bits_driven = 0;
		send_frame();
		wait_frame_done();
		if (error_seen)
		begin
			$display("Error at %0t: error_out raised during a clean frame", $time);
			other_errors++;
		end
		// Done follows the strobe of the last EOF bit
		if (done_seen && (done_bit != frame_bits.size()))
		begin
			$display("Fail %0t frame_done bit got %0d expected %0d",
				$time, done_bit, frame_bits.size());
			value_errors++;
		end

		// Fields hold until the next SOF
		id_a_cmp("id_a", id_a, ida);
		id_b_cmp("id_b", id_b, ext ? idb : '0);
		dlc_cmp("dlc", dlc, code);
		data_cmp("data", data, exp_data);
		crc_cmp("crc", crc, frame_crc);
		bit_cmp("ide", ide, ext);
		bit_cmp("rtr", rtr, remote);
		bit_cmp("srr", srr, ext);
		bit_cmp("reserved1", reserved1, ext & reserved_tx[1]);
		bit_cmp("reserved0", reserved0, reserved_tx[0]);
		bit_cmp("ack_slot", ack_slot, 1'b0);
		send_idle(3);
	endtask

	// Sends the corrupted frame_bits, then idles until recovery
	task automatic run_error_frame(input string what, input int exp_bit);
		done_seen = 1'b0;
		error_seen = 1'b0;
		bits_driven = 0;
		send_frame();
		if (!error_seen)
		begin
			$display("Error at %0t: no error_out for the %s", $time, what);
			other_errors++;
		end
		else if (error_bit != exp_bit)
		begin
			$display("Fail %0t error_out rise bit got %0d expected %0d",
				$time, error_bit, exp_bit);
			value_errors++;
		end
		if (done_seen)
		begin
			$display("Error at %0t: frame_done pulsed for the %s", $time, what);
			other_errors++;
		end
		wait_error_release();
	endtask

	task automatic run_random_frame(input logic ext);
		can_pkg::id_a_t ida;
		can_pkg::id_b_t idb;
		can_pkg::dlc_t code;
		can_pkg::data_t payload;

		ida = can_pkg::id_a_t'(next_random());
		idb = can_pkg::id_b_t'(next_random());
		code = can_pkg::dlc_t'(next_random() % 8 + 1);
		payload[63:32] = next_random();
		payload[31:0] = next_random();
		run_clean_frame(ext, ida, idb, 1'b0, code, payload);
	endtask

	// ==========================================================
	// Tests
	// ==========================================================

	task automatic check_reset_state();
		bit_cmp("frame_done", frame_done, 1'b0);
		bit_cmp("error_out", error_out, 1'b0);
		id_a_cmp("id_a", id_a, '0);
		id_b_cmp("id_b", id_b, '0);
		dlc_cmp("dlc", dlc, '0);
		data_cmp("data", data, '0);
		crc_cmp("crc", crc, '0);
		bit_cmp("ide", ide, 1'b0);
		bit_cmp("rtr", rtr, 1'b0);
		bit_cmp("srr", srr, 1'b0);
		bit_cmp("reserved1", reserved1, 1'b0);
		bit_cmp("reserved0", reserved0, 1'b0);
		bit_cmp("ack_slot", ack_slot, 1'b0);
	endtask

	task automatic test_standard_frames();
		repeat (4) run_random_frame(1'b0);
	endtask

	// Receivers accept either level in the reserved bits
	task automatic test_extended_frames();
		reserved_tx = 2'b10;
		run_random_frame(1'b1);
		reserved_tx = 2'b01;
		run_random_frame(1'b1);
		reserved_tx = 2'b00;
		run_random_frame(1'b1);
	endtask

	task automatic test_remote_and_empty();
		can_pkg::data_t payload;

		payload[63:32] = next_random();
		payload[31:0] = next_random();
		// Remote frames with nonzero DLC still carry no data
		run_clean_frame(1'b0, 11'h123, '0, 1'b1, 4'd5, payload);
		run_clean_frame(1'b1, 11'h2a5, 18'h1c3f0, 1'b1, 4'd8, payload);
		run_clean_frame(1'b0, 11'h0f0, '0, 1'b0, 4'd0, payload);
		// DLC 12 clamps to eight bytes
		run_clean_frame(1'b0, 11'h555, '0, 1'b0, 4'd12, payload);
	endtask

	// Long equal runs, stuff bit every fifth position
	task automatic test_stuffing();
		run_clean_frame(1'b0, '0, '0, 1'b0, 4'd8, '0);
		run_clean_frame(1'b0, '1, '0, 1'b0, 4'd8, '1);
		run_clean_frame(1'b1, '0, '0, 1'b0, 4'd8, '0);
		run_clean_frame(1'b1, '1, '1, 1'b0, 4'd8, '1);
	endtask

	task automatic test_crc_error();
		can_pkg::crc_t flip;

		flip = can_pkg::crc_t'(1) << (next_random() % can_pkg::CRC_LEN);
		encode_frame(1'b0, 11'h3a7, '0, 1'b0, 4'd3, 64'h0000_0000_00c3_5a91, flip);
		// Mismatch shows in the CRC delimiter bit
		run_error_frame("frame with a corrupted CRC", frame_bits.size() - can_pkg::EOF_LEN - 2);
		run_random_frame(1'b0);
	endtask

	task automatic test_stuff_error();
		int pos;
		int i;

		encode_frame(1'b0, 11'h4b1, '0, 1'b0, 4'd8, '0, '0);
		// First stuff bit inside the data field
		pos = -1;
		for (i = 0; i < stuff_pos.size(); i++)
			if ((pos < 0) && (stuff_pos[i] > data_pos))
				pos = stuff_pos[i];
		if (pos < 0)
		begin
			$display("Error at %0t: encoder placed no stuff bit in the data field", $time);
			other_errors++;
		end
		else
		begin
			// Stuff bit repeats the run, six equal bits
			frame_bits[pos] = ~frame_bits[pos];
			run_error_frame("frame with six equal data bits", pos + 1);
		end
		run_random_frame(1'b1);
	endtask

	task automatic test_eof_error();
		encode_frame(1'b0, 11'h61c, '0, 1'b0, 4'd2, 64'h0000_0000_0000_beef, '0);
		// Third EOF bit pulled dominant
		frame_bits[frame_bits.size() - can_pkg::EOF_LEN + 2] = 1'b0;
		run_error_frame("frame with a dominant EOF bit", frame_bits.size() - can_pkg::EOF_LEN + 3);
		run_random_frame(1'b0);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial
	begin
		rng = 32'h986b_4e77;
		value_errors = 0;
		other_errors = 0;
		done_seen = 1'b0;
		error_seen = 1'b0;
		bits_driven = 0;
		done_bit = 0;
		error_bit = 0;
		recessive_run = 0;
		reserved_tx = 2'b00;
		reset = 1'b1;
		sample_point = 1'b0;
		rx_bit = 1'b1;

		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_reset_state();

		test_standard_frames();
		test_extended_frames();
		test_remote_and_empty();
		test_stuffing();
		test_crc_error();
		test_stuff_error();
		test_eof_error();

		$display("Checks done: %0d wrong values, %0d other failures",
			value_errors, other_errors);
		if ((value_errors + other_errors) == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/can_decoder_props.sv */
`default_nettype none

module can_decoder_props (
	input logic clock,
	input logic reset,
	input logic sample_point,
	input logic frame_done,
	input logic error_out
);

	// ==========================================================
	// Output pulse rules
	// ==========================================================

	// Done is a single-cycle pulse
	done_single_cycle: assert property (@(posedge clock) disable iff (reset)
		frame_done |=> !frame_done)
	else $error("frame_done stayed high for more than one cycle");

	// A frame either completes or fails, never both at once
	done_error_exclusive: assert property (@(posedge clock) disable iff (reset)
		!($rose(frame_done) && $rose(error_out)))
	else $error("frame_done and error_out rose in the same cycle");

	// Quiet outputs as reset releases
	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> (!frame_done && !error_out))
	else $error("decoder outputs active right after reset");

	// Errors are only detected on a strobe
	error_after_strobe: assert property (@(posedge clock) disable iff (reset)
		$rose(error_out) |-> $past(sample_point))
	else $error("error_out rose without a preceding strobe");

endmodule

bind can_decoder can_decoder_props props (
	.clock        (clock),
	.reset        (reset),
	.sample_point (sample_point),
	.frame_done   (frame_done),
	.error_out    (error_out)
);

`default_nettype wire

/* rtl/can_decoder.sv */
`default_nettype none

module can_decoder (
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	output logic error_out,
	output logic frame_done,
	output can_pkg::id_a_t id_a,
	output can_pkg::id_b_t id_b,
	output can_pkg::dlc_t dlc,
	output can_pkg::data_t data,
	output can_pkg::crc_t crc,
	output logic ide,
	output logic rtr,
	output logic srr,
	output logic reserved1,
	output logic reserved0,
	output logic ack_slot
);

	// Destuffer handshake with the sequencer
	logic frame_start;
	logic stuffed_region;
	logic stuff_bit;
	logic stuff_error;

	// CRC engine
	logic crc_clear;
	logic crc_shift;
	can_pkg::crc_t crc_value;

	// Field shifter controls and counts
	logic shift_id_a;
	logic shift_id_b;
	logic shift_dlc;
	logic shift_data;
	logic shift_crc;
	can_pkg::bit_count_t id_a_count;
	can_pkg::bit_count_t id_b_count;
	can_pkg::bit_count_t dlc_count;
	can_pkg::bit_count_t data_count;
	can_pkg::bit_count_t crc_count;

	// ==========================================================
	// Bit level
	// ==========================================================

	can_bit_destuffer u_destuffer (
		.clock          (clock),
		.reset          (reset),
		.sample_point   (sample_point),
		.rx_bit         (rx_bit),
		.frame_start    (frame_start),
		.stuffed_region (stuffed_region),
		.stuff_bit      (stuff_bit),
		.stuff_error    (stuff_error)
	);

	can_crc15 u_crc (
		.clock     (clock),
		.reset     (reset),
		.clear     (crc_clear),
		.shift     (crc_shift),
		.data_bit  (rx_bit),
		.crc_value (crc_value)
	);

	// ==========================================================
	// Multi-bit fields, all cleared at SOF
	// ==========================================================

	can_field_shifter #(.field_t(can_pkg::id_a_t)) u_id_a (
		.clock  (clock),
		.reset  (reset),
		.clear  (frame_start),
		.shift  (shift_id_a),
		.rx_bit (rx_bit),
		.field  (id_a),
		.count  (id_a_count)
	);

	can_field_shifter #(.field_t(can_pkg::id_b_t)) u_id_b (
		.clock  (clock),
		.reset  (reset),
		.clear  (frame_start),
		.shift  (shift_id_b),
		.rx_bit (rx_bit),
		.field  (id_b),
		.count  (id_b_count)
	);

	can_field_shifter #(.field_t(can_pkg::dlc_t)) u_dlc (
		.clock  (clock),
		.reset  (reset),
		.clear  (frame_start),
		.shift  (shift_dlc),
		.rx_bit (rx_bit),
		.field  (dlc),
		.count  (dlc_count)
	);

	can_field_shifter #(.field_t(can_pkg::data_t)) u_data (
		.clock  (clock),
		.reset  (reset),
		.clear  (frame_start),
		.shift  (shift_data),
		.rx_bit (rx_bit),
		.field  (data),
		.count  (data_count)
	);

	// Received CRC, compared in the delimiter slot
	can_field_shifter #(.field_t(can_pkg::crc_t)) u_crc_field (
		.clock  (clock),
		.reset  (reset),
		.clear  (frame_start),
		.shift  (shift_crc),
		.rx_bit (rx_bit),
		.field  (crc),
		.count  (crc_count)
	);

	// ==========================================================
	// Frame sequencer
	// ==========================================================

	can_frame_fsm u_fsm (
		.clock          (clock),
		.reset          (reset),
		.sample_point   (sample_point),
		.rx_bit         (rx_bit),
		.stuff_bit      (stuff_bit),
		.stuff_error    (stuff_error),
		.id_a_count     (id_a_count),
		.id_b_count     (id_b_count),
		.dlc_count      (dlc_count),
		.data_count     (data_count),
		.crc_count      (crc_count),
		.dlc            (dlc),
		.rx_crc         (crc),
		.crc_value      (crc_value),
		.frame_start    (frame_start),
		.stuffed_region (stuffed_region),
		.crc_clear      (crc_clear),
		.crc_shift      (crc_shift),
		.shift_id_a     (shift_id_a),
		.shift_id_b     (shift_id_b),
		.shift_dlc      (shift_dlc),
		.shift_data     (shift_data),
		.shift_crc      (shift_crc),
		.ide            (ide),
		.rtr            (rtr),
		.srr            (srr),
		.reserved1      (reserved1),
		.reserved0      (reserved0),
		.ack_slot       (ack_slot),
		.frame_done     (frame_done),
		.error_out      (error_out)
	);

endmodule

`default_nettype wire

/* rtl/can_frame_fsm.sv */
`default_nettype none

module can_frame_fsm (
	input  logic clock,
	input  logic reset,
	input  logic sample_point,
	input  logic rx_bit,
	input  logic stuff_bit,
	input  logic stuff_error,
	input  can_pkg::bit_count_t id_a_count,
	input  can_pkg::bit_count_t id_b_count,
	input  can_pkg::bit_count_t dlc_count,
	input  can_pkg::bit_count_t data_count,
	input  can_pkg::bit_count_t crc_count,
	input  can_pkg::dlc_t dlc,
	input  can_pkg::crc_t rx_crc,
	input  can_pkg::crc_t crc_value,
	output logic frame_start,
	output logic stuffed_region,
	output logic crc_clear,
	output logic crc_shift,
	output logic shift_id_a,
	output logic shift_id_b,
	output logic shift_dlc,
	output logic shift_data,
	output logic shift_crc,
	output logic ide,
	output logic rtr,
	output logic srr,
	output logic reserved1,
	output logic reserved0,
	output logic ack_slot,
	output logic frame_done,
	output logic error_out
);

	can_pkg::dec_state_t state;
	can_pkg::dec_state_t next_state;

	// Shared bit counter for EOF, intermission and recovery
	logic [3:0] run_count;
	// Bit after IDE in a standard frame, SRR in an extended one
	logic rtr_srr;
	logic bit_ok;
	logic last_ifs;
	logic frame_error;
	can_pkg::dlc_t dlc_next;
	can_pkg::dlc_t dlc_bytes;
	can_pkg::bit_count_t data_bits;

	// Destuffed bit strobe
	assign bit_ok = sample_point & ~stuff_bit;

	assign last_ifs = (state == can_pkg::ST_INTERFRAME)
		& (run_count == can_pkg::INTERFRAME_LEN - 1);

	// Dominant bit while idle or at the end of intermission
	assign frame_start = sample_point & ~rx_bit & ((state == can_pkg::ST_IDLE) | last_ifs);

	// Delimiter slot included, a trailing CRC run puts its stuff bit there
	assign stuffed_region = state inside {can_pkg::ST_ID_A, can_pkg::ST_RTR_SRR,
		can_pkg::ST_IDE, can_pkg::ST_ID_B, can_pkg::ST_RTR, can_pkg::ST_RESERVED1,
		can_pkg::ST_RESERVED0, can_pkg::ST_DLC, can_pkg::ST_DATA, can_pkg::ST_CRC,
		can_pkg::ST_CRC_DELIMITER};

	// SOF is a zero into a zero seed, so clearing on it loses nothing
	assign crc_clear = frame_start;
	assign crc_shift = bit_ok & (state inside {can_pkg::ST_ID_A, can_pkg::ST_RTR_SRR,
		can_pkg::ST_IDE, can_pkg::ST_ID_B, can_pkg::ST_RTR, can_pkg::ST_RESERVED1,
		can_pkg::ST_RESERVED0, can_pkg::ST_DLC, can_pkg::ST_DATA});

	// One shift per destuffed bit of each multi-bit field
	assign shift_id_a = bit_ok & (state == can_pkg::ST_ID_A);
	assign shift_id_b = bit_ok & (state == can_pkg::ST_ID_B);
	assign shift_dlc = bit_ok & (state == can_pkg::ST_DLC);
	assign shift_data = bit_ok & (state == can_pkg::ST_DATA);
	assign shift_crc = bit_ok & (state == can_pkg::ST_CRC);

	assign error_out = (state == can_pkg::ST_ERROR);

	// Full DLC in its last bit, before the shifter catches up
	assign dlc_next = {dlc[can_pkg::DLC_LEN-2:0], rx_bit};

	// DLC 9 to 15 still means eight bytes
	assign dlc_bytes = (dlc > can_pkg::MAX_DATA_BYTES) ? can_pkg::dlc_t'(can_pkg::MAX_DATA_BYTES) : dlc;
	assign data_bits = rtr ? '0 : {dlc_bytes, 3'b000};

	// ==========================================================
	// Error detection
	// ==========================================================

	always_comb
	begin
		frame_error = 1'b0;
		if (sample_point)
		begin
			if (stuff_error)
				frame_error = 1'b1;
			else if (!stuff_bit)
			begin
				case (state)
					// Extended frame needs a recessive SRR
					can_pkg::ST_IDE: frame_error = rx_bit & ~rtr_srr;
					can_pkg::ST_CRC_DELIMITER: frame_error = ~rx_bit | (rx_crc != crc_value);
					// No receiver acknowledged
					can_pkg::ST_ACK_SLOT: frame_error = rx_bit;
					can_pkg::ST_ACK_DELIMITER: frame_error = ~rx_bit;
					can_pkg::ST_EOF: frame_error = ~rx_bit;
					can_pkg::ST_INTERFRAME: frame_error = ~rx_bit & ~last_ifs;
					default: frame_error = 1'b0;
				endcase
			end
		end
	end

	// ==========================================================
	// Next state
	// ==========================================================

	always_comb
	begin
		next_state = state;
		if (frame_error)
			next_state = can_pkg::ST_ERROR;
		else if (bit_ok)
		begin
			case (state)
				can_pkg::ST_IDLE:
					if (!rx_bit)
						next_state = can_pkg::ST_ID_A;
				can_pkg::ST_ID_A:
					if (id_a_count == can_pkg::ID_A_LEN - 1)
						next_state = can_pkg::ST_RTR_SRR;
				can_pkg::ST_RTR_SRR: next_state = can_pkg::ST_IDE;
				// Recessive IDE selects the extended format
				can_pkg::ST_IDE: next_state = rx_bit ? can_pkg::ST_ID_B : can_pkg::ST_RESERVED0;
				can_pkg::ST_ID_B:
					if (id_b_count == can_pkg::ID_B_LEN - 1)
						next_state = can_pkg::ST_RTR;
				can_pkg::ST_RTR: next_state = can_pkg::ST_RESERVED1;
				can_pkg::ST_RESERVED1: next_state = can_pkg::ST_RESERVED0;
				can_pkg::ST_RESERVED0: next_state = can_pkg::ST_DLC;
				can_pkg::ST_DLC:
					if (dlc_count == can_pkg::DLC_LEN - 1)
					begin
						// Remote and empty frames skip the data field
						if (rtr || (dlc_next == '0))
							next_state = can_pkg::ST_CRC;
						else
							next_state = can_pkg::ST_DATA;
					end
				can_pkg::ST_DATA:
					if ((data_count + 1'b1) == data_bits)
						next_state = can_pkg::ST_CRC;
				can_pkg::ST_CRC:
					if (crc_count == can_pkg::CRC_LEN - 1)
						next_state = can_pkg::ST_CRC_DELIMITER;
				can_pkg::ST_CRC_DELIMITER: next_state = can_pkg::ST_ACK_SLOT;
				can_pkg::ST_ACK_SLOT: next_state = can_pkg::ST_ACK_DELIMITER;
				can_pkg::ST_ACK_DELIMITER: next_state = can_pkg::ST_EOF;
				can_pkg::ST_EOF:
					if (run_count == can_pkg::EOF_LEN - 1)
						next_state = can_pkg::ST_INTERFRAME;
				can_pkg::ST_INTERFRAME:
					if (last_ifs)
						next_state = rx_bit ? can_pkg::ST_IDLE : can_pkg::ST_ID_A;
				// Leave only after a full idle run of recessive bits
				can_pkg::ST_ERROR:
					if (rx_bit && (run_count == can_pkg::IDLE_RUN - 1))
						next_state = can_pkg::ST_IDLE;
				default: next_state = can_pkg::ST_IDLE;
			endcase
		end
	end

	// ==========================================================
	// State, run counter and done pulse
	// ==========================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= can_pkg::ST_IDLE;
			run_count <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			// Last EOF bit accepted cleanly
			frame_done <= sample_point & (state == can_pkg::ST_EOF)
				& (next_state == can_pkg::ST_INTERFRAME);
			if (sample_point)
			begin
				state <= next_state;
				if (next_state != state)
					run_count <= '0;
				else if ((state == can_pkg::ST_ERROR) && !rx_bit)
					// Dominant bit restarts the idle wait
					run_count <= '0;
				else if (state inside {can_pkg::ST_EOF, can_pkg::ST_INTERFRAME, can_pkg::ST_ERROR})
					run_count <= run_count + 4'd1;
			end
		end
	end

	// ==========================================================
	// Single-bit fields
	// ==========================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rtr_srr <= 1'b0;
			ide <= 1'b0;
			rtr <= 1'b0;
			srr <= 1'b0;
			reserved1 <= 1'b0;
			reserved0 <= 1'b0;
			ack_slot <= 1'b0;
		end
		else if (frame_start)
		begin
			rtr_srr <= 1'b0;
			ide <= 1'b0;
			rtr <= 1'b0;
			srr <= 1'b0;
			reserved1 <= 1'b0;
			reserved0 <= 1'b0;
			ack_slot <= 1'b0;
		end
		else if (bit_ok)
		begin
			case (state)
				can_pkg::ST_RTR_SRR: rtr_srr <= rx_bit;
				can_pkg::ST_IDE:
				begin
					ide <= rx_bit;
					// Shared bit resolves once IDE is known
					if (rx_bit)
						srr <= rtr_srr;
					else
						rtr <= rtr_srr;
				end
				can_pkg::ST_RTR: rtr <= rx_bit;
				can_pkg::ST_RESERVED1: reserved1 <= rx_bit;
				can_pkg::ST_RESERVED0: reserved0 <= rx_bit;
				can_pkg::ST_ACK_SLOT: ack_slot <= rx_bit;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/can_field_shifter.sv */
`default_nettype none

module can_field_shifter #(
	parameter type field_t = logic [7:0]
) (
	input  logic clock,
	input  logic reset,
	input  logic clear,
	input  logic shift,
	input  logic rx_bit,
	output field_t field,
	output can_pkg::bit_count_t count
);

	// ==========================================================
	// Field capture
	// ==========================================================

	// MSB first on the bus, so bits enter at the LSB end
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			field <= '0;
			count <= '0;
		end
		else if (clear)
		begin
			// New frame, drop the previous value
			field <= '0;
			count <= '0;
		end
		else if (shift)
		begin
			field <= {field[$bits(field_t)-2:0], rx_bit};
			// Sequencer ends the field from this count
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/can_crc15.sv */
`default_nettype none

module can_crc15 (
	input  logic clock,
	input  logic reset,
	input  logic clear,
	input  logic shift,
	input  logic data_bit,
	output can_pkg::crc_t crc_value
);

	// Incoming bit against the register MSB
	logic feedback;
	can_pkg::crc_t shifted;

	assign feedback = data_bit ^ crc_value[can_pkg::CRC_LEN-1];

	// One step of the register before the polynomial is applied
	assign shifted = {crc_value[can_pkg::CRC_LEN-2:0], 1'b0};

	// ==========================================================
	// Serial LFSR
	// ==========================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			crc_value <= '0;
		end
		else if (clear)
		begin
			// Zero seed per CAN
			crc_value <= '0;
		end
		else if (shift)
		begin
			if (feedback)
				crc_value <= shifted ^ can_pkg::CRC_POLY;
			else
				crc_value <= shifted;
		end
	end

endmodule

`default_nettype wire

/* rtl/can_bit_destuffer.sv */
`default_nettype none

module can_bit_destuffer (
	input  logic clock,
	input  logic reset,
	input  logic sample_point,
	input  logic rx_bit,
	input  logic frame_start,
	input  logic stuffed_region,
	output logic stuff_bit,
	output logic stuff_error
);

	// Last sampled bus bits, newest in bit 0
	logic [can_pkg::STUFF_RUN-1:0] history;
	logic run_complete;

	// Five equal bits seen, so this position carries a stuff bit
	assign run_complete = (history == '0) | (history == '1);

	// Only meaningful from the identifier up to the CRC delimiter slot
	assign stuff_bit = sample_point & stuffed_region & run_complete;

	// Stuff bit repeating the run makes six equal bits
	assign stuff_error = stuff_bit & (rx_bit == history[0]);

	// ==========================================================
	// Bit history
	// ==========================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			history <= '0;
		end
		else if (sample_point)
		begin
			if (frame_start)
				// SOF starts a fresh run of one, older slots opposite
				history <= {{(can_pkg::STUFF_RUN-1){~rx_bit}}, rx_bit};
			else
				// Stuff bits stay in the history, they open the next run
				history <= {history[can_pkg::STUFF_RUN-2:0], rx_bit};
		end
	end

endmodule

`default_nettype wire

/* rtl/can_pkg.sv */
`default_nettype none

package can_pkg;

	// ==========================================================
	// Frame field lengths
	// ==========================================================

	// Identifier parts, base then extended
	localparam int ID_A_LEN = 11;
	localparam int ID_B_LEN = 18;

	// Length code and payload
	localparam int DLC_LEN = 4;
	localparam int MAX_DATA_BYTES = 8;

	localparam int CRC_LEN = 15;

	// Recessive tail of a frame
	localparam int EOF_LEN = 7;
	// Third intermission bit may already be the next SOF
	localparam int INTERFRAME_LEN = 2;

	// Bit stuffing run and bus idle detection
	localparam int STUFF_RUN = 5;
	localparam int IDLE_RUN = 11;

	// ==========================================================
	// Field types
	// ==========================================================

	typedef logic [ID_A_LEN-1:0] id_a_t;
	typedef logic [ID_B_LEN-1:0] id_b_t;
	typedef logic [DLC_LEN-1:0] dlc_t;
	// Right-aligned, short frames leave the upper bytes zero
	typedef logic [MAX_DATA_BYTES*8-1:0] data_t;
	typedef logic [CRC_LEN-1:0] crc_t;
	// Must reach the full 64 data bits
	typedef logic [$clog2(MAX_DATA_BYTES*8+1)-1:0] bit_count_t;

	// CAN CRC-15 generator, x^15 term implied
	localparam crc_t CRC_POLY = 15'h4599;

	// ==========================================================
	// Decoder state
	// ==========================================================

	typedef enum logic [4:0] {
		ST_IDLE,
		ST_ID_A,
		ST_RTR_SRR,
		ST_IDE,
		ST_ID_B,
		ST_RTR,
		ST_RESERVED1,
		ST_RESERVED0,
		ST_DLC,
		ST_DATA,
		ST_CRC,
		ST_CRC_DELIMITER,
		ST_ACK_SLOT,
		ST_ACK_DELIMITER,
		ST_EOF,
		ST_INTERFRAME,
		ST_ERROR
	} dec_state_t;

endpackage

`default_nettype wire
